/* all.f */
verilog/nlb_csr_pkg.sv
verilog/nlb_lpbk_pkg.sv
verilog/nlb_csr.sv
verilog/rd_stream.sv
verilog/wr_stream.sv
verilog/lpbk_arbiter.sv
verilog/nlb_top.sv
test/tb_nlb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the nlb_top testbench with Verilator, run it, and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_nlb \
   -f all.f -o sim_nlb > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_nlb > sim.log 2>&1
cat sim.log

grep -q "^All tests passed$" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* test/tb_nlb.sv */
// Memory model answers after 1 to 4 cycles and raises mem_almost_full at random; rows need num_lines > 0
`timescale 1ns/1ps

module tb_nlb;
   import nlb_csr_pkg::*;
   import nlb_lpbk_pkg::*;

   localparam int RD_TIMEOUT = 8;
   localparam int POLL_LIMIT = 500;
   localparam int NUM_ROWS   = 5;

   // One test setup and how it ends
   typedef struct {
      t_test_mode mode;
      t_line_addr src;
      t_line_addr dst;
      t_count     num_lines;
      logic       cont;
      t_test_cfg  cfg;
      // Cycles from start to force, 0 for no force
      int         force_dly;
   } t_row;

   logic                  Clk_400;
   logic                  rst;
   logic                  csr_wr_en;
   logic                  csr_rd_en;
   logic [CSR_ADDR_W-1:0] csr_addr;
   logic [CSR_DATA_W-1:0] csr_wr_data;
   logic [CSR_DATA_W-1:0] csr_rd_data;
   logic                  csr_rd_valid;
   logic                  mem_req_valid;
   t_mem_op               mem_req_op;
   t_line_addr            mem_req_addr;
   t_line_data            mem_req_data;
   logic                  mem_almost_full;
   logic                  mem_rd_rsp;
   logic                  mem_wr_rsp;

   // Requests seen on the port, by op
   t_line_addr rd_addr_q[$];
   t_line_addr wr_addr_q[$];
   t_line_data wr_data_q[$];
   // Cycle at which each pending response is due
   int         rd_due_q[$];
   int         wr_due_q[$];
   int         cyc;
   t_row       rows[NUM_ROWS];

   nlb_top nlb_top_inst (
      .Clk_400(Clk_400), .rst(rst),
      .csr_wr_en(csr_wr_en), .csr_rd_en(csr_rd_en), .csr_addr(csr_addr),
      .csr_wr_data(csr_wr_data), .csr_rd_data(csr_rd_data), .csr_rd_valid(csr_rd_valid),
      .mem_req_valid(mem_req_valid), .mem_req_op(mem_req_op),
      .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
      .mem_almost_full(mem_almost_full), .mem_rd_rsp(mem_rd_rsp), .mem_wr_rsp(mem_wr_rsp)
   );

   // 40 ns period
   initial
   begin
      Clk_400 = 1'b0;
      forever #20 Clk_400 = ~Clk_400;
   end

   // ----------------------------------------
   // Error handling and compares
   // ----------------------------------------
   task automatic halt_on_error();
      $display("Some tests failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic abort_run(input string why);
      $display("error at %0t: %s", $time, why);
      halt_on_error();
   endtask

   task automatic check_count(input string what, input t_count got, input t_count exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
         halt_on_error();
      end
   endtask

   task automatic check_addr(input string what, input t_line_addr got, input t_line_addr exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         halt_on_error();
      end
   endtask

   task automatic check_data(input string what, input t_line_data got, input t_line_data exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         halt_on_error();
      end
   endtask

   task automatic check_reg(input string what, input logic [CSR_DATA_W-1:0] got,
                            input logic [CSR_DATA_W-1:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
         halt_on_error();
      end
   endtask

   // ----------------------------------------
   // Memory model
   // ----------------------------------------
   initial
   begin
      mem_almost_full = 1'b0;
      mem_rd_rsp      = 1'b0;
      mem_wr_rsp      = 1'b0;
      cyc             = 0;
      forever
      begin
         @(posedge Clk_400);
         cyc = cyc + 1;
         #2;
         // About one cycle in four is blocked
         mem_almost_full = (($urandom % 4) == 0);
         // At most one pulse per op and cycle, oldest first
         mem_rd_rsp = 1'b0;
         if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc)
         begin
            void'(rd_due_q.pop_front());
            mem_rd_rsp = 1'b1;
         end
         mem_wr_rsp = 1'b0;
         if (wr_due_q.size() > 0 && wr_due_q[0] <= cyc)
         begin
            void'(wr_due_q.pop_front());
            mem_wr_rsp = 1'b1;
         end
         // Request outputs are settled mid-cycle
         @(negedge Clk_400);
         if (mem_req_valid)
         begin
            if (mem_almost_full)
               abort_run("a request was issued while mem_almost_full was high");
            if (mem_req_op == OP_RD)
            begin
               rd_addr_q.push_back(mem_req_addr);
               rd_due_q.push_back(cyc + $urandom_range(1, 4));
            end
            else
            begin
               wr_addr_q.push_back(mem_req_addr);
               wr_data_q.push_back(mem_req_data);
               wr_due_q.push_back(cyc + $urandom_range(1, 4));
            end
         end
      end
   end

   // ----------------------------------------
   // Register port access
   // ----------------------------------------
   task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr,
                            input logic [CSR_DATA_W-1:0] data);
      @(posedge Clk_400);
      #2;
      csr_wr_en   = 1'b1;
      csr_addr    = addr;
      csr_wr_data = data;
      @(posedge Clk_400);
      #2;
      csr_wr_en = 1'b0;
   endtask

   task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr,
                           output logic [CSR_DATA_W-1:0] data);
      int waited;
      @(posedge Clk_400);
      #2;
      csr_rd_en = 1'b1;
      csr_addr  = addr;
      @(posedge Clk_400);
      #2;
      csr_rd_en = 1'b0;
      waited    = 0;
      while (csr_rd_valid !== 1'b1)
      begin
         if (waited == RD_TIMEOUT)
            abort_run("register read never returned valid data");
         @(negedge Clk_400);
         waited++;
      end
      data = csr_rd_data;
   endtask

   task automatic verify_reg(input logic [CSR_ADDR_W-1:0] addr,
                             input logic [CSR_DATA_W-1:0] exp, input string what);
      logic [CSR_DATA_W-1:0] got;
      read_reg(addr, got);
      check_reg(what, got, exp);
   endtask

   // Config word from mode, cont and test_cfg fields
   function automatic logic [CSR_DATA_W-1:0] pack_cfg(input t_row r);
      logic [CSR_DATA_W-1:0] w;
      w                                     = '0;
      w[CFG_CONT_BIT]                       = r.cont;
      w[CFG_MODE_LSB +: CFG_MODE_W]         = r.mode;
      w[CFG_TEST_CFG_LSB +: CFG_TEST_CFG_W] = r.cfg;
      return w;
   endfunction

   // ----------------------------------------
   // One table row from reset to checks
   // ----------------------------------------
   task automatic run_row(input t_row r);
      logic [CSR_DATA_W-1:0] rd_data;
      logic                  has_rd;
      logic                  has_wr;
      int                    polls;
      int                    i;
      t_line_data            exp_data;
      has_rd = (r.mode == M_READ) || (r.mode == M_TRPUT);
      has_wr = (r.mode == M_WRITE) || (r.mode == M_TRPUT);
      // Test reset, then release it with start low
      write_reg(CSR_CTL, 32'h0);
      write_reg(CSR_CTL, 32'h1);
      rd_addr_q.delete();
      wr_addr_q.delete();
      wr_data_q.delete();
      write_reg(CSR_SRC_ADDR, CSR_DATA_W'(r.src));
      write_reg(CSR_DST_ADDR, CSR_DATA_W'(r.dst));
      write_reg(CSR_NUM_LINES, r.num_lines);
      write_reg(CSR_CFG, pack_cfg(r));
      // Start with reset released
      write_reg(CSR_CTL, 32'h3);
      if (r.cont)
      begin
         // Setup is locked while running
         write_reg(CSR_CFG, ~pack_cfg(r));
         write_reg(CSR_SRC_ADDR, CSR_DATA_W'(r.src) + 32'h100);
         verify_reg(CSR_CFG, pack_cfg(r), "config written during run");
         verify_reg(CSR_SRC_ADDR, CSR_DATA_W'(r.src), "source written during run");
      end
      if (r.force_dly > 0)
      begin
         repeat (r.force_dly) @(posedge Clk_400);
         write_reg(CSR_CTL, 32'h7);
      end
      polls   = 0;
      rd_data = '0;
      while (rd_data[0] !== 1'b1)
      begin
         if (polls == POLL_LIMIT)
            abort_run("test did not complete within the status poll limit");
         read_reg(CSR_STATUS, rd_data);
         polls++;
      end
      check_reg("status", rd_data, 32'h1);

      // Request counts by mode; a forced run keeps what the model saw
      if (!has_rd)
         check_count("read requests", t_count'(rd_addr_q.size()), '0);
      else if (r.force_dly == 0)
         check_count("read requests", t_count'(rd_addr_q.size()), r.num_lines);
      if (!has_wr)
         check_count("write requests", t_count'(wr_addr_q.size()), '0);
      else if (r.force_dly == 0)
         check_count("write requests", t_count'(wr_addr_q.size()), r.num_lines);
      if (r.cont && has_rd && rd_addr_q.size() <= r.num_lines)
         abort_run("continuous read stream never wrapped");
      if (r.cont && has_wr && wr_addr_q.size() <= r.num_lines)
         abort_run("continuous write stream never wrapped");
      if (!r.cont && r.force_dly > 0
          && ((has_rd && rd_addr_q.size() >= r.num_lines)
              || (has_wr && wr_addr_q.size() >= r.num_lines)))
         abort_run("forced completion did not end the run early");

      // Line order, wrapping after num_lines
      for (i = 0; i < rd_addr_q.size(); i++)
         check_addr("read address", rd_addr_q[i], r.src + t_line_addr'(i % r.num_lines));
      for (i = 0; i < wr_addr_q.size(); i++)
      begin
         exp_data = {r.cfg, 24'h0, t_count'(i % r.num_lines)};
         check_addr("write address", wr_addr_q[i], r.dst + t_line_addr'(i % r.num_lines));
         check_data("write data", wr_data_q[i], exp_data);
      end

      // Status counters against the model
      read_reg(CSR_NUM_READS, rd_data);
      check_count("NUM_READS", rd_data, t_count'(rd_addr_q.size()));
      read_reg(CSR_NUM_WRITES, rd_data);
      check_count("NUM_WRITES", rd_data, t_count'(wr_addr_q.size()));
      read_reg(CSR_NUM_CLOCKS, rd_data);
      if (rd_data < CSR_DATA_W'(rd_addr_q.size() + wr_addr_q.size()))
      begin
         $display("mismatch at %0t: NUM_CLOCKS %0d is below the %0d requests issued",
                  $time, rd_data, rd_addr_q.size() + wr_addr_q.size());
         halt_on_error();
      end
   endtask

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      logic [CSR_DATA_W-1:0] rd_data;
      logic [CSR_DATA_W-1:0] scratch_val;
      int                    k;
      rst         = 1'b1;
      csr_wr_en   = 1'b0;
      csr_rd_en   = 1'b0;
      csr_addr    = '0;
      csr_wr_data = '0;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(32'h451f_8d36));
      scratch_val = $urandom;

      // mode, src, dst, num_lines, cont, test_cfg, force delay
      rows[0] = '{M_READ,  20'h01000, 20'h00000, 32'd8,   1'b0, 8'h00, 0};
      rows[1] = '{M_WRITE, 20'h00000, 20'h02000, 32'd6,   1'b0, 8'ha5, 0};
      rows[2] = '{M_TRPUT, 20'h03000, 20'h04000, 32'd12,  1'b0, 8'h3c, 0};
      rows[3] = '{M_TRPUT, 20'h05000, 20'h06000, 32'd4,   1'b1, 8'h5a, 40};
      rows[4] = '{M_WRITE, 20'h00000, 20'h07000, 32'd200, 1'b0, 8'hc3, 30};

      repeat (2) @(posedge Clk_400);
      #2;
      rst = 1'b0;

      // Plain register readback
      write_reg(CSR_SCRATCH, scratch_val);
      verify_reg(CSR_SCRATCH, scratch_val, "scratchpad");
      write_reg(CSR_SRC_ADDR, 32'h000a_bcde);
      verify_reg(CSR_SRC_ADDR, 32'h000a_bcde, "source address");
      write_reg(CSR_DST_ADDR, 32'h000f_00d0);
      verify_reg(CSR_DST_ADDR, 32'h000f_00d0, "destination address");
      write_reg(CSR_NUM_LINES, 32'h0000_0123);
      verify_reg(CSR_NUM_LINES, 32'h0000_0123, "line count");
      write_reg(CSR_CFG, 32'h0ab0_000c);
      verify_reg(CSR_CFG, 32'h0ab0_000c, "config");
      // Holes in the map
      for (k = 6; k < 16; k++)
         if (k == 6 || k == 7 || k >= 12)
            verify_reg(CSR_ADDR_W'(k), '0, "unmapped address");

      for (k = 0; k < NUM_ROWS; k++)
         run_row(rows[k]);

      // Test reset clears status and counters
      write_reg(CSR_CTL, 32'h0);
      verify_reg(CSR_STATUS, '0, "status after test reset");
      read_reg(CSR_NUM_READS, rd_data);
      check_count("NUM_READS after test reset", rd_data, '0);
      read_reg(CSR_NUM_WRITES, rd_data);
      check_count("NUM_WRITES after test reset", rd_data, '0);
      read_reg(CSR_NUM_CLOCKS, rd_data);
      check_count("NUM_CLOCKS after test reset", rd_data, '0);

      $display("All tests passed");
      $finish;
   end

endmodule

/* verilog/nlb_top.sv */
// Plain strobe memory port with 64-bit lines. Responses are untagged pulses, one per request
`timescale 1ns/1ps

module nlb_top
(
   input  logic                                  Clk_400,
   input  logic                                  rst,
   // Register port
   input  logic                                  csr_wr_en,
   input  logic                                  csr_rd_en,
   input  logic [nlb_csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
   input  logic [nlb_csr_pkg::CSR_DATA_W-1:0]    csr_wr_data,
   output logic [nlb_csr_pkg::CSR_DATA_W-1:0]    csr_rd_data,
   output logic                                  csr_rd_valid,
   // Memory port
   output logic                                  mem_req_valid,
   output nlb_lpbk_pkg::t_mem_op                 mem_req_op,
   output nlb_lpbk_pkg::t_line_addr              mem_req_addr,
   output nlb_lpbk_pkg::t_line_data              mem_req_data,
   input  logic                                  mem_almost_full,
   input  logic                                  mem_rd_rsp,
   input  logic                                  mem_wr_rsp
);
   import nlb_lpbk_pkg::*;

   // ----------------------------------------
   // Test setup from the registers
   // ----------------------------------------
   logic       test_go;
   logic       test_rst;
   logic       force_cmp;
   logic       cont;
   t_test_mode mode;
   t_count     num_lines;
   t_line_addr src_addr;
   t_line_addr dst_addr;
   t_test_cfg  test_cfg;

   // Status back to the registers
   logic       test_cmp;
   t_count     num_reads;
   t_count     num_writes;
   t_count     num_clocks;

   // ----------------------------------------
   // Stream to arbiter
   // ----------------------------------------
   logic       rd_req_valid;
   t_line_addr rd_req_addr;
   logic       rd_grant;
   logic       rd_done;
   logic       wr_req_valid;
   t_line_addr wr_req_addr;
   t_line_data wr_req_data;
   logic       wr_grant;
   logic       wr_done;

   nlb_csr nlb_csr_inst (
      .Clk_400(Clk_400), .rst(rst),
      .csr_wr_en(csr_wr_en), .csr_rd_en(csr_rd_en), .csr_addr(csr_addr),
      .csr_wr_data(csr_wr_data), .csr_rd_data(csr_rd_data), .csr_rd_valid(csr_rd_valid),
      .test_cmp(test_cmp), .num_reads(num_reads), .num_writes(num_writes),
      .num_clocks(num_clocks),
      .test_go(test_go), .test_rst(test_rst), .force_cmp(force_cmp), .cont(cont),
      .mode(mode), .num_lines(num_lines), .src_addr(src_addr), .dst_addr(dst_addr),
      .test_cfg(test_cfg)
   );

   rd_stream rd_stream_inst (
      .Clk_400(Clk_400), .rst(rst), .test_rst(test_rst), .test_go(test_go),
      .force_cmp(force_cmp), .cont(cont), .mode(mode),
      .num_lines(num_lines), .src_addr(src_addr),
      .grant(rd_grant), .mem_rd_rsp(mem_rd_rsp),
      .req_valid(rd_req_valid), .req_addr(rd_req_addr),
      .done(rd_done), .num_reads(num_reads)
   );

   wr_stream wr_stream_inst (
      .Clk_400(Clk_400), .rst(rst), .test_rst(test_rst), .test_go(test_go),
      .force_cmp(force_cmp), .cont(cont), .mode(mode),
      .num_lines(num_lines), .dst_addr(dst_addr), .test_cfg(test_cfg),
      .grant(wr_grant), .mem_wr_rsp(mem_wr_rsp),
      .req_valid(wr_req_valid), .req_addr(wr_req_addr), .req_data(wr_req_data),
      .done(wr_done), .num_writes(num_writes)
   );

   lpbk_arbiter lpbk_arbiter_inst (
      .Clk_400(Clk_400), .rst(rst), .test_rst(test_rst), .test_go(test_go), .mode(mode),
      .rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr),
      .wr_req_valid(wr_req_valid), .wr_req_addr(wr_req_addr), .wr_req_data(wr_req_data),
      .rd_grant(rd_grant), .wr_grant(wr_grant), .rd_done(rd_done), .wr_done(wr_done),
      .mem_almost_full(mem_almost_full),
      .mem_req_valid(mem_req_valid), .mem_req_op(mem_req_op),
      .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
      .test_cmp(test_cmp), .num_clocks(num_clocks)
   );

endmodule

/* verilog/lpbk_arbiter.sv */
// Memory request outputs are combinational from the granted stream. No request while almost full
`timescale 1ns/1ps

module lpbk_arbiter
(
   input  logic                       Clk_400,
   input  logic                       rst,
   input  logic                       test_rst,
   input  logic                       test_go,
   input  nlb_lpbk_pkg::t_test_mode   mode,
   input  logic                       rd_req_valid,
   input  nlb_lpbk_pkg::t_line_addr   rd_req_addr,
   input  logic                       wr_req_valid,
   input  nlb_lpbk_pkg::t_line_addr   wr_req_addr,
   input  nlb_lpbk_pkg::t_line_data   wr_req_data,
   output logic                       rd_grant,
   output logic                       wr_grant,
   input  logic                       rd_done,
   input  logic                       wr_done,
   input  logic                       mem_almost_full,
   output logic                       mem_req_valid,
   output nlb_lpbk_pkg::t_mem_op      mem_req_op,
   output nlb_lpbk_pkg::t_line_addr   mem_req_addr,
   output nlb_lpbk_pkg::t_line_data   mem_req_data,
   output logic                       test_cmp,
   output nlb_lpbk_pkg::t_count       num_clocks
);
   import nlb_lpbk_pkg::*;

   // Op of the last grant, the other one wins a tie
   t_mem_op last_op;
   logic    all_done;

   // ----------------------------------------
   // Round-robin grant
   // ----------------------------------------
   assign rd_grant = !mem_almost_full && rd_req_valid && (!wr_req_valid || last_op == OP_WR);
   assign wr_grant = !mem_almost_full && wr_req_valid && (!rd_req_valid || last_op == OP_RD);

   // Port follows the winner
   assign mem_req_valid = rd_grant | wr_grant;
   assign mem_req_op    = wr_grant ? OP_WR : OP_RD;
   assign mem_req_addr  = wr_grant ? wr_req_addr : rd_req_addr;
   assign mem_req_data  = wr_grant ? wr_req_data : '0;

   // Streams not in this mode count as done
   assign all_done = (!mode_has_rd(mode) || rd_done) && (!mode_has_wr(mode) || wr_done);

   always_ff @(posedge Clk_400)
   begin
      if (rst || test_rst)
      begin
         last_op    <= OP_WR;
         test_cmp   <= 1'b0;
         num_clocks <= '0;
      end
      else
      begin
         if (mem_req_valid)
            last_op <= mem_req_op;
         // Sticky until test reset
         if (test_go && all_done)
            test_cmp <= 1'b1;
         // Run time from go up to completion
         if (test_go && !test_cmp)
            num_clocks <= num_clocks + 1'b1;
      end
   end

   a_one_grant: assert property (@(posedge Clk_400) disable iff (rst || test_rst)
      !(rd_grant && wr_grant));

   a_no_req_when_full: assert property (@(posedge Clk_400) disable iff (rst || test_rst)
      mem_req_valid |-> !mem_almost_full);

endmodule

/* verilog/wr_stream.sv */
// Line data is index in 31:0 and test_cfg in 63:56. Responses are only counted
`timescale 1ns/1ps

module wr_stream
(
   input  logic                       Clk_400,
   input  logic                       rst,
   input  logic                       test_rst,
   input  logic                       test_go,
   input  logic                       force_cmp,
   input  logic                       cont,
   input  nlb_lpbk_pkg::t_test_mode   mode,
   input  nlb_lpbk_pkg::t_count       num_lines,
   input  nlb_lpbk_pkg::t_line_addr   dst_addr,
   input  nlb_lpbk_pkg::t_test_cfg    test_cfg,
   input  logic                       grant,
   input  logic                       mem_wr_rsp,
   output logic                       req_valid,
   output nlb_lpbk_pkg::t_line_addr   req_addr,
   output nlb_lpbk_pkg::t_line_data   req_data,
   output logic                       done,
   output nlb_lpbk_pkg::t_count       num_writes
);
   import nlb_lpbk_pkg::*;

   t_strm_state state;
   t_count      line_idx;
   t_count      out_cnt;
   t_count      out_next;
   logic        last_line;

   assign last_line = (line_idx == num_lines - 1'b1);
   assign req_valid = (state == S_ISSUE) && !force_cmp;
   assign req_addr  = dst_addr + line_idx[ADDR_LMT-1:0];
   // Pattern {cfg byte, zero pad, line index}
   assign req_data  = {test_cfg, {(LINE_DATA_W - COUNT_W - 8){1'b0}}, line_idx};
   assign done      = (state == S_DONE);
   assign out_next  = out_cnt + t_count'(grant) - t_count'(mem_wr_rsp);

   always_ff @(posedge Clk_400)
   begin
      if (rst || test_rst)
      begin
         state      <= S_IDLE;
         line_idx   <= '0;
         out_cnt    <= '0;
         num_writes <= '0;
      end
      else
      begin
         out_cnt <= out_next;
         if (mem_wr_rsp)
            num_writes <= num_writes + 1'b1;
         if (grant)
            line_idx <= last_line ? '0 : line_idx + 1'b1;
         case (state)
            S_IDLE:
               if (test_go && mode_has_wr(mode))
                  state <= (num_lines == '0) ? S_DRAIN : S_ISSUE;
            // Continuous runs leave only on force
            S_ISSUE:
               if (force_cmp || (grant && last_line && !cont))
                  state <= S_DRAIN;
            S_DRAIN:
               if (out_next == '0)
                  state <= S_DONE;
            default: state <= state;
         endcase
      end
   end

   a_no_orphan_rsp: assert property (@(posedge Clk_400) disable iff (rst || test_rst)
      mem_wr_rsp |-> (out_cnt != '0));

endmodule

/* verilog/rd_stream.sv */
// Holds req_valid until granted. Responses carry no address and are only counted
`timescale 1ns/1ps

module rd_stream
(
   input  logic                       Clk_400,
   input  logic                       rst,
   input  logic                       test_rst,
   input  logic                       test_go,
   input  logic                       force_cmp,
   input  logic                       cont,
   input  nlb_lpbk_pkg::t_test_mode   mode,
   input  nlb_lpbk_pkg::t_count       num_lines,
   input  nlb_lpbk_pkg::t_line_addr   src_addr,
   input  logic                       grant,
   input  logic                       mem_rd_rsp,
   output logic                       req_valid,
   output nlb_lpbk_pkg::t_line_addr   req_addr,
   output logic                       done,
   output nlb_lpbk_pkg::t_count       num_reads
);
   import nlb_lpbk_pkg::*;

   t_strm_state state;
   t_count      line_idx;
   t_count      out_cnt;
   t_count      out_next;
   logic        last_line;

   assign last_line = (line_idx == num_lines - 1'b1);
   // Force stops issue at once, even mid-run
   assign req_valid = (state == S_ISSUE) && !force_cmp;
   assign req_addr  = src_addr + line_idx[ADDR_LMT-1:0];
   assign done      = (state == S_DONE);
   // Outstanding count after this cycle's grant and response
   assign out_next  = out_cnt + t_count'(grant) - t_count'(mem_rd_rsp);

   always_ff @(posedge Clk_400)
   begin
      if (rst || test_rst)
      begin
         state     <= S_IDLE;
         line_idx  <= '0;
         out_cnt   <= '0;
         num_reads <= '0;
      end
      else
      begin
         out_cnt <= out_next;
         if (mem_rd_rsp)
            num_reads <= num_reads + 1'b1;
         // Wrap back to the start after n lines
         if (grant)
            line_idx <= last_line ? '0 : line_idx + 1'b1;
         case (state)
            S_IDLE:
               if (test_go && mode_has_rd(mode))
                  state <= (num_lines == '0) ? S_DRAIN : S_ISSUE;
            S_ISSUE:
               if (force_cmp || (grant && last_line && !cont))
                  state <= S_DRAIN;
            S_DRAIN:
               if (out_next == '0)
                  state <= S_DONE;
            default: state <= state;
         endcase
      end
   end

   // Memory returns only what was requested
   a_no_orphan_rsp: assert property (@(posedge Clk_400) disable iff (rst || test_rst)
      mem_rd_rsp |-> (out_cnt != '0));

endmodule

/* verilog/nlb_csr.sv */
// Reads return data one cycle after csr_rd_en. Address registers keep only the low 20 bits
`timescale 1ns/1ps

module nlb_csr
(
   input  logic                                  Clk_400,
   input  logic                                  rst,
   input  logic                                  csr_wr_en,
   input  logic                                  csr_rd_en,
   input  logic [nlb_csr_pkg::CSR_ADDR_W-1:0]    csr_addr,
   input  logic [nlb_csr_pkg::CSR_DATA_W-1:0]    csr_wr_data,
   output logic [nlb_csr_pkg::CSR_DATA_W-1:0]    csr_rd_data,
   output logic                                  csr_rd_valid,
   input  logic                                  test_cmp,
   input  nlb_lpbk_pkg::t_count                  num_reads,
   input  nlb_lpbk_pkg::t_count                  num_writes,
   input  nlb_lpbk_pkg::t_count                  num_clocks,
   output logic                                  test_go,
   output logic                                  test_rst,
   output logic                                  force_cmp,
   output logic                                  cont,
   output nlb_lpbk_pkg::t_test_mode              mode,
   output nlb_lpbk_pkg::t_count                  num_lines,
   output nlb_lpbk_pkg::t_line_addr              src_addr,
   output nlb_lpbk_pkg::t_line_addr              dst_addr,
   output nlb_lpbk_pkg::t_test_cfg               test_cfg
);
   import nlb_csr_pkg::*;
   import nlb_lpbk_pkg::*;

   logic [CSR_DATA_W-1:0]      scratch;
   logic [CSR_DATA_W-1:0]      cfg_q;
   logic [CTL_FORCE_CMP_BIT:0] ctl_q;
   // High from go until completion
   logic                       wr_lock;

   // ----------------------------------------
   // Control decode
   // ----------------------------------------
   assign test_rst  = ~ctl_q[CTL_TEST_RST_N_BIT];
   assign test_go   = ctl_q[CTL_TEST_RST_N_BIT] & ctl_q[CTL_START_BIT];
   assign force_cmp = ctl_q[CTL_FORCE_CMP_BIT];
   assign wr_lock   = test_go & ~test_cmp;

   // Config fields
   assign cont     = cfg_q[CFG_CONT_BIT];
   assign mode     = t_test_mode'(cfg_q[CFG_MODE_LSB +: CFG_MODE_W]);
   assign test_cfg = cfg_q[CFG_TEST_CFG_LSB +: CFG_TEST_CFG_W];

   // ----------------------------------------
   // Register writes
   // ----------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rst)
      begin
         scratch   <= '0;
         cfg_q     <= '0;
         ctl_q     <= '0;
         src_addr  <= '0;
         dst_addr  <= '0;
         num_lines <= '0;
      end
      else if (csr_wr_en)
      begin
         case (csr_addr)
            CSR_SCRATCH:   scratch <= csr_wr_data;
            // Control stays writable so a running test can be forced or reset
            CSR_CTL:       ctl_q <= csr_wr_data[CTL_FORCE_CMP_BIT:0];
            CSR_SRC_ADDR:
               if (!wr_lock)
                  src_addr <= csr_wr_data[ADDR_LMT-1:0];
            CSR_DST_ADDR:
               if (!wr_lock)
                  dst_addr <= csr_wr_data[ADDR_LMT-1:0];
            CSR_NUM_LINES:
               if (!wr_lock)
                  num_lines <= csr_wr_data;
            CSR_CFG:
               if (!wr_lock)
                  cfg_q <= csr_wr_data;
            default: ;
         endcase
      end
   end

   // ----------------------------------------
   // Read path, one cycle latency
   // ----------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (rst)
         csr_rd_valid <= 1'b0;
      else
         csr_rd_valid <= csr_rd_en;
   end

   always_ff @(posedge Clk_400)
   begin
      case (csr_addr)
         CSR_SCRATCH:    csr_rd_data <= scratch;
         CSR_SRC_ADDR:   csr_rd_data <= CSR_DATA_W'(src_addr);
         CSR_DST_ADDR:   csr_rd_data <= CSR_DATA_W'(dst_addr);
         CSR_NUM_LINES:  csr_rd_data <= num_lines;
         CSR_CTL:        csr_rd_data <= CSR_DATA_W'(ctl_q);
         CSR_CFG:        csr_rd_data <= cfg_q;
         CSR_STATUS:     csr_rd_data <= CSR_DATA_W'(test_cmp);
         CSR_NUM_READS:  csr_rd_data <= num_reads;
         CSR_NUM_WRITES: csr_rd_data <= num_writes;
         CSR_NUM_CLOCKS: csr_rd_data <= num_clocks;
         // Unmapped words read zero
         default:        csr_rd_data <= '0;
      endcase
   end

   // Read data never shows up unrequested
   a_rd_valid_follows_en: assert property (@(posedge Clk_400) disable iff (rst)
      csr_rd_valid |-> $past(csr_rd_en));

endmodule

/* verilog/nlb_lpbk_pkg.sv */
// Line-granular addressing with 64-bit lines. Mode values outside READ, WRITE and TRPUT run no stream
package nlb_lpbk_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int ADDR_LMT    = 20;
   localparam int LINE_DATA_W = 64;
   localparam int COUNT_W     = 32;

   typedef logic [ADDR_LMT-1:0]    t_line_addr;
   typedef logic [LINE_DATA_W-1:0] t_line_data;
   typedef logic [COUNT_W-1:0]     t_count;
   // Free byte passed into the write data pattern
   typedef logic [7:0]             t_test_cfg;

   // ----------------------------------------
   // Test modes and memory ops
   // ----------------------------------------
   typedef enum logic [2:0] {
      M_READ  = 3'b001,
      M_WRITE = 3'b010,
      M_TRPUT = 3'b011
   } t_test_mode;

   typedef enum logic {
      OP_RD = 1'b0,
      OP_WR = 1'b1
   } t_mem_op;

   // Stream sequencing, shared by both engines
   typedef enum logic [1:0] {
      S_IDLE,
      S_ISSUE,
      S_DRAIN,
      S_DONE
   } t_strm_state;

   // Mode decode, one place for streams and arbiter
   function automatic logic mode_has_rd(t_test_mode m);
      return (m == M_READ) || (m == M_TRPUT);
   endfunction

   function automatic logic mode_has_wr(t_test_mode m);
      return (m == M_WRITE) || (m == M_TRPUT);
   endfunction

endpackage

/* verilog/nlb_csr_pkg.sv */
// Word-addressed register map with 32-bit registers. Bit 0 of CSR_CTL is an active-low test reset
package nlb_csr_pkg;

   // Register port widths
   localparam int CSR_DATA_W = 32;
   localparam int CSR_ADDR_W = 4;

   // ----------------------------------------
   // Word addresses
   // ----------------------------------------
   // Configuration and control, read/write
   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH    = 4'd0;
   localparam logic [CSR_ADDR_W-1:0] CSR_SRC_ADDR   = 4'd1;
   localparam logic [CSR_ADDR_W-1:0] CSR_DST_ADDR   = 4'd2;
   localparam logic [CSR_ADDR_W-1:0] CSR_NUM_LINES  = 4'd3;
   localparam logic [CSR_ADDR_W-1:0] CSR_CTL        = 4'd4;
   localparam logic [CSR_ADDR_W-1:0] CSR_CFG        = 4'd5;
   // Status, read only
   // Completion flag sits in bit 0 of CSR_STATUS
   localparam logic [CSR_ADDR_W-1:0] CSR_STATUS     = 4'd8;
   localparam logic [CSR_ADDR_W-1:0] CSR_NUM_READS  = 4'd9;
   localparam logic [CSR_ADDR_W-1:0] CSR_NUM_WRITES = 4'd10;
   localparam logic [CSR_ADDR_W-1:0] CSR_NUM_CLOCKS = 4'd11;

   // ----------------------------------------
   // Control word bits
   // ----------------------------------------
   // Low holds the test in reset
   localparam int CTL_TEST_RST_N_BIT = 0;
   localparam int CTL_START_BIT      = 1;
   localparam int CTL_FORCE_CMP_BIT  = 2;

   // ----------------------------------------
   // Config word fields
   // ----------------------------------------
   localparam int CFG_CONT_BIT     = 1;
   localparam int CFG_MODE_LSB     = 2;
   localparam int CFG_MODE_W       = 3;
   localparam int CFG_TEST_CFG_LSB = 20;
   localparam int CFG_TEST_CFG_W   = 8;

endpackage
